//--- design/turf_pkg.sv
package turf_pkg;

    // register bus widths
    localparam int ADR_W = 28;
    localparam int DAT_W = 32;

    // opcode sits above the address in the first request word
    localparam int OP_LSB = 28;

    // request opcodes, anything else is ignored by the decoder
    typedef enum logic [3:0] {
        MM_OP_READ  = 4'd1,
        MM_OP_WRITE = 4'd2
    } mm_op_e;

    // request decoder states
    typedef enum logic [1:0] {
        DEC_ADDR = 2'd0,
        DEC_DATA = 2'd1,
        DEC_BUS  = 2'd2,
        DEC_RESP = 2'd3
    } dec_state_e;

    // register map
    localparam logic [ADR_W-1:0] REG_IDENT       = 28'd0;
    localparam logic [ADR_W-1:0] REG_DATEVERSION = 28'd1;
    localparam logic [ADR_W-1:0] REG_CTRL        = 28'd2;
    localparam logic [ADR_W-1:0] REG_SCRATCH     = 28'd3;

endpackage

//--- design/mm_fifo.sv
`timescale 1ns/1ps
module mm_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic [turf_pkg::DAT_W-1:0] wr_data_i,
    input  logic                      wr_en_i,
    output logic                      full_o,
    output logic [turf_pkg::DAT_W-1:0] rd_data_o,
    input  logic                      rd_en_i,
    output logic                      empty_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [turf_pkg::DAT_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic do_wr;
    logic do_rd;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == CNT_W'(FIFO_DEPTH));

    // a read frees a slot in the same cycle, so full still accepts with a pop
    assign do_rd = rd_en_i && !empty_o;
    assign do_wr = wr_en_i && (!full_o || do_rd);

    // first word falls through
    assign rd_data_o = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

//--- design/mm_req_decoder.sv
`timescale 1ns/1ps
module mm_req_decoder (
    input  logic                       clk,
    input  logic                       reset_i,
    // request queue, first-word-fall-through
    input  logic [turf_pkg::DAT_W-1:0] req_data_i,
    input  logic                       req_empty_i,
    output logic                       req_rden_o,
    // register bus master
    output logic                       bus_en_o,
    output logic                       bus_wr_o,
    output logic [turf_pkg::ADR_W-1:0] bus_adr_o,
    output logic [turf_pkg::DAT_W-1:0] bus_dat_o,
    input  logic                       bus_ack_i,
    input  logic [turf_pkg::DAT_W-1:0] bus_dat_i,
    // response queue
    output logic [turf_pkg::DAT_W-1:0] resp_data_o,
    output logic                       resp_wren_o,
    input  logic                       resp_full_i
);

    turf_pkg::dec_state_e state_q;
    turf_pkg::dec_state_e state_d;
    turf_pkg::mm_op_e     op_q;
    logic [turf_pkg::ADR_W-1:0] adr_q;
    logic [turf_pkg::DAT_W-1:0] dat_q;
    logic [turf_pkg::DAT_W-1:0] resp_q;
    logic op_known;
    logic op_write;

    assign op_write = (op_q == turf_pkg::MM_OP_WRITE);
    assign op_known = op_write || (op_q == turf_pkg::MM_OP_READ);

    // both words of a pair are popped as soon as they show up
    assign req_rden_o = !req_empty_i &&
                        ((state_q == turf_pkg::DEC_ADDR) || (state_q == turf_pkg::DEC_DATA));

    assign bus_en_o  = (state_q == turf_pkg::DEC_BUS);
    assign bus_wr_o  = op_write;
    assign bus_adr_o = adr_q;
    assign bus_dat_o = dat_q;

    // response waits here while the queue is full
    assign resp_wren_o = (state_q == turf_pkg::DEC_RESP) && !resp_full_i;
    assign resp_data_o = resp_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            turf_pkg::DEC_ADDR: begin
                if (!req_empty_i) begin
                    state_d = turf_pkg::DEC_DATA;
                end
            end
            turf_pkg::DEC_DATA: begin
                if (!req_empty_i) begin
                    // unknown opcode: pair consumed, nothing else
                    state_d = op_known ? turf_pkg::DEC_BUS : turf_pkg::DEC_ADDR;
                end
            end
            turf_pkg::DEC_BUS: begin
                if (bus_ack_i) begin
                    state_d = op_write ? turf_pkg::DEC_ADDR : turf_pkg::DEC_RESP;
                end
            end
            turf_pkg::DEC_RESP: begin
                if (!resp_full_i) begin
                    state_d = turf_pkg::DEC_ADDR;
                end
            end
            default: state_d = turf_pkg::DEC_ADDR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= turf_pkg::DEC_ADDR;
        end else begin
            state_q <= state_d;
        end
    end

    // captured words of the pair and the read result
    always_ff @(posedge clk) begin
        if (state_q == turf_pkg::DEC_ADDR && !req_empty_i) begin
            op_q  <= turf_pkg::mm_op_e'(req_data_i[turf_pkg::DAT_W-1:turf_pkg::OP_LSB]);
            adr_q <= req_data_i[turf_pkg::ADR_W-1:0];
        end
        if (state_q == turf_pkg::DEC_DATA && !req_empty_i) begin
            dat_q <= req_data_i;
        end
        if (state_q == turf_pkg::DEC_BUS && bus_ack_i) begin
            resp_q <= bus_dat_i;
        end
    end

endmodule

//--- design/bus_arbiter.sv
`timescale 1ns/1ps
module bus_arbiter (
    input  logic                       clk,
    input  logic                       reset_i,
    // master 0
    input  logic                       m0_en_i,
    input  logic                       m0_wr_i,
    input  logic [turf_pkg::ADR_W-1:0] m0_adr_i,
    input  logic [turf_pkg::DAT_W-1:0] m0_dat_i,
    output logic                       m0_ack_o,
    output logic [turf_pkg::DAT_W-1:0] m0_dat_o,
    // master 1
    input  logic                       m1_en_i,
    input  logic                       m1_wr_i,
    input  logic [turf_pkg::ADR_W-1:0] m1_adr_i,
    input  logic [turf_pkg::DAT_W-1:0] m1_dat_i,
    output logic                       m1_ack_o,
    output logic [turf_pkg::DAT_W-1:0] m1_dat_o,
    // shared slave side
    output logic                       s_en_o,
    output logic                       s_wr_o,
    output logic [turf_pkg::ADR_W-1:0] s_adr_o,
    output logic [turf_pkg::DAT_W-1:0] s_dat_o,
    input  logic                       s_ack_i,
    input  logic [turf_pkg::DAT_W-1:0] s_dat_i
);

    logic busy_q;
    logic grant_q;
    logic last_q;
    logic pick;

    // on a tie, serve whoever did not go last
    assign pick = (m0_en_i && m1_en_i) ? !last_q : m1_en_i;

    assign s_en_o  = busy_q && (grant_q ? m1_en_i : m0_en_i);
    assign s_wr_o  = grant_q ? m1_wr_i  : m0_wr_i;
    assign s_adr_o = grant_q ? m1_adr_i : m0_adr_i;
    assign s_dat_o = grant_q ? m1_dat_i : m0_dat_i;

    assign m0_ack_o = busy_q && !grant_q && s_ack_i;
    assign m1_ack_o = busy_q && grant_q && s_ack_i;
    assign m0_dat_o = (busy_q && !grant_q) ? s_dat_i : '0;
    assign m1_dat_o = (busy_q && grant_q) ? s_dat_i : '0;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q  <= 1'b0;
            grant_q <= 1'b0;
            // external master (0) wins the first tie
            last_q  <= 1'b1;
        end else if (!busy_q) begin
            if (m0_en_i || m1_en_i) begin
                busy_q  <= 1'b1;
                grant_q <= pick;
                last_q  <= pick;
            end
        end else if (s_ack_i) begin
            busy_q <= 1'b0;
        end
    end

endmodule

//--- design/turf_register_core.sv
`timescale 1ns/1ps
module turf_register_core #(
    parameter logic [31:0] IDENT       = "TFSM",
    parameter logic [31:0] DATEVERSION = 32'h0000_0007
) (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       en_i,
    input  logic                       wr_i,
    input  logic [turf_pkg::ADR_W-1:0] adr_i,
    input  logic [turf_pkg::DAT_W-1:0] dat_i,
    output logic                       ack_o,
    output logic [turf_pkg::DAT_W-1:0] dat_o,
    output logic [turf_pkg::DAT_W-1:0] ctrl_o
);

    logic ack_q;
    logic [turf_pkg::DAT_W-1:0] ctrl_q;
    logic [turf_pkg::DAT_W-1:0] scratch_q;
    logic access;

    // en is still high in the ack cycle, so skip that one
    assign access = en_i && !ack_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q     <= 1'b0;
            ctrl_q    <= '0;
            scratch_q <= '0;
        end else begin
            ack_q <= access;
            if (access && wr_i) begin
                if (adr_i == turf_pkg::REG_CTRL) begin
                    ctrl_q <= dat_i;
                end
                if (adr_i == turf_pkg::REG_SCRATCH) begin
                    scratch_q <= dat_i;
                end
            end
        end
    end

    // read mux, address is held through the ack cycle
    always_comb begin
        case (adr_i)
            turf_pkg::REG_IDENT:       dat_o = IDENT;
            turf_pkg::REG_DATEVERSION: dat_o = DATEVERSION;
            turf_pkg::REG_CTRL:        dat_o = ctrl_q;
            turf_pkg::REG_SCRATCH:     dat_o = scratch_q;
            default:                   dat_o = '0;
        endcase
    end

    assign ack_o  = ack_q;
    assign ctrl_o = ctrl_q;

endmodule

//--- design/turf_host_bridge.sv
`timescale 1ns/1ps
module turf_host_bridge #(
    parameter int          FIFO_DEPTH    = 8,
    parameter logic [31:0] IDENT         = "TFSM",
    parameter logic [3:0]  VER_MAJOR     = 4'd0,
    parameter logic [3:0]  VER_MINOR     = 4'd0,
    parameter logic [7:0]  VER_REV       = 8'd7,
    parameter logic [15:0] FIRMWARE_DATE = 16'h0000
) (
    input  logic                       clk,
    input  logic                       reset_i,
    // host request queue
    input  logic [turf_pkg::DAT_W-1:0] req_data_i,
    input  logic                       req_wren_i,
    output logic                       req_full_o,
    // host response queue
    output logic [turf_pkg::DAT_W-1:0] resp_data_o,
    input  logic                       resp_rden_i,
    output logic                       resp_empty_o,
    // external bus master, stands in for the udp control path
    input  logic                       ext_en_i,
    input  logic                       ext_wr_i,
    input  logic [turf_pkg::ADR_W-1:0] ext_adr_i,
    input  logic [turf_pkg::DAT_W-1:0] ext_dat_i,
    output logic                       ext_ack_o,
    output logic [turf_pkg::DAT_W-1:0] ext_dat_o,
    output logic [turf_pkg::DAT_W-1:0] ctrl_o
);

    // date in the top half, major.minor.rev below
    localparam logic [31:0] DATEVERSION = {FIRMWARE_DATE, VER_MAJOR, VER_MINOR, VER_REV};

    logic [turf_pkg::DAT_W-1:0] req_word;
    logic                       req_empty;
    logic                       req_rden;
    logic [turf_pkg::DAT_W-1:0] resp_word;
    logic                       resp_wren;
    logic                       resp_full;

    // decoder side of the bus
    logic                       dec_en;
    logic                       dec_wr;
    logic [turf_pkg::ADR_W-1:0] dec_adr;
    logic [turf_pkg::DAT_W-1:0] dec_wdat;
    logic                       dec_ack;
    logic [turf_pkg::DAT_W-1:0] dec_rdat;

    // core side of the bus
    logic                       en;
    logic                       wr;
    logic [turf_pkg::ADR_W-1:0] adr;
    logic [turf_pkg::DAT_W-1:0] dat_out;
    logic                       ack;
    logic [turf_pkg::DAT_W-1:0] dat_in;

    mm_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_req_fifo (
        .clk(clk), .reset_i(reset_i),
        .wr_data_i(req_data_i), .wr_en_i(req_wren_i), .full_o(req_full_o),
        .rd_data_o(req_word), .rd_en_i(req_rden), .empty_o(req_empty)
    );

    mm_req_decoder u_decoder (
        .clk(clk), .reset_i(reset_i),
        .req_data_i(req_word), .req_empty_i(req_empty), .req_rden_o(req_rden),
        .bus_en_o(dec_en), .bus_wr_o(dec_wr), .bus_adr_o(dec_adr), .bus_dat_o(dec_wdat),
        .bus_ack_i(dec_ack), .bus_dat_i(dec_rdat),
        .resp_data_o(resp_word), .resp_wren_o(resp_wren), .resp_full_i(resp_full)
    );

    mm_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_resp_fifo (
        .clk(clk), .reset_i(reset_i),
        .wr_data_i(resp_word), .wr_en_i(resp_wren), .full_o(resp_full),
        .rd_data_o(resp_data_o), .rd_en_i(resp_rden_i), .empty_o(resp_empty_o)
    );

    // external port is master 0, decoder is master 1
    bus_arbiter u_arbiter (
        .clk(clk), .reset_i(reset_i),
        .m0_en_i(ext_en_i), .m0_wr_i(ext_wr_i), .m0_adr_i(ext_adr_i), .m0_dat_i(ext_dat_i),
        .m0_ack_o(ext_ack_o), .m0_dat_o(ext_dat_o),
        .m1_en_i(dec_en), .m1_wr_i(dec_wr), .m1_adr_i(dec_adr), .m1_dat_i(dec_wdat),
        .m1_ack_o(dec_ack), .m1_dat_o(dec_rdat),
        .s_en_o(en), .s_wr_o(wr), .s_adr_o(adr), .s_dat_o(dat_out),
        .s_ack_i(ack), .s_dat_i(dat_in)
    );

    turf_register_core #(.IDENT(IDENT), .DATEVERSION(DATEVERSION)) u_registers (
        .clk(clk), .reset_i(reset_i),
        .en_i(en), .wr_i(wr), .adr_i(adr), .dat_i(dat_out),
        .ack_o(ack), .dat_o(dat_in), .ctrl_o(ctrl_o)
    );

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps
module tb_clock_gen #(
    parameter int HALF_PERIOD = 10
) (
    output logic clk_o
);

    // 20 ns period, first rising edge at 10 ns
    initial begin
        clk_o = 1'b0;
    end

    always #(HALF_PERIOD) clk_o = ~clk_o;

endmodule

//--- test/turf_host_bridge_checker.sv
`timescale 1ns/1ps
module turf_host_bridge_checker (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       en_i,
    input  logic [turf_pkg::ADR_W-1:0] adr_i,
    input  logic                       ack_i,
    input  turf_pkg::dec_state_e       dec_state_i
);

    int unsigned assert_fails = 0;

    // a pending request is answered next cycle with the address unchanged
    hold_until_ack: assert property (@(posedge clk) disable iff (reset_i)
        (en_i && !ack_i) |=> (ack_i && $stable(adr_i)))
        else begin
            assert_fails++;
            $error("core bus request not held with a stable address until ack");
        end

    single_cycle_ack: assert property (@(posedge clk) disable iff (reset_i)
        ack_i |=> !ack_i)
        else begin
            assert_fails++;
            $error("core bus ack lasted more than one cycle");
        end

    ack_after_en: assert property (@(posedge clk) disable iff (reset_i)
        ack_i |-> $past(en_i))
        else begin
            assert_fails++;
            $error("core bus ack without a preceding en");
        end

    // with alternation the decoder waits behind at most one external access
    decoder_bus_bounded: assert property (@(posedge clk) disable iff (reset_i)
        $rose(dec_state_i == turf_pkg::DEC_BUS) |->
            ##[1:5] (dec_state_i != turf_pkg::DEC_BUS))
        else begin
            assert_fails++;
            $error("decoder waited too long for its bus access");
        end

endmodule

bind turf_host_bridge turf_host_bridge_checker u_checker (
    .clk(clk),
    .reset_i(reset_i),
    .en_i(en),
    .adr_i(adr),
    .ack_i(ack),
    .dec_state_i(u_decoder.state_q)
);

//--- test/tb_turf_host_bridge.sv
`timescale 1ns/1ps
module tb_turf_host_bridge;

    localparam int FIFO_DEPTH = 8;
    localparam int TIMEOUT = 300;
    // long enough for the decoder to finish a pair uncontended
    localparam int QUIET_CYCLES = 20;
    // response queue, the word held in the decoder, then request pairs
    localparam int FILL_PAIRS = FIFO_DEPTH + 1 + FIFO_DEPTH / 2;
    localparam logic [turf_pkg::DAT_W-1:0] EXP_IDENT = "TFSM";
    localparam logic [turf_pkg::DAT_W-1:0] EXP_DATEVERSION = 32'h1234_0007;

    logic                       clk;
    logic                       reset_i;
    logic [turf_pkg::DAT_W-1:0] req_data_i;
    logic                       req_wren_i;
    logic                       req_full_o;
    logic [turf_pkg::DAT_W-1:0] resp_data_o;
    logic                       resp_rden_i;
    logic                       resp_empty_o;
    logic                       ext_en_i;
    logic                       ext_wr_i;
    logic [turf_pkg::ADR_W-1:0] ext_adr_i;
    logic [turf_pkg::DAT_W-1:0] ext_dat_i;
    logic                       ext_ack_o;
    logic [turf_pkg::DAT_W-1:0] ext_dat_o;
    logic [turf_pkg::DAT_W-1:0] ctrl_o;

    int err_count;
    int timeout_count;
    int total_fails;
    // last value written to control
    logic [turf_pkg::DAT_W-1:0] ctrl_model;

    tb_clock_gen u_clk_gen (.clk_o(clk));

    turf_host_bridge #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .FIRMWARE_DATE(16'h1234)
    ) uut (
        .clk(clk), .reset_i(reset_i),
        .req_data_i(req_data_i), .req_wren_i(req_wren_i), .req_full_o(req_full_o),
        .resp_data_o(resp_data_o), .resp_rden_i(resp_rden_i), .resp_empty_o(resp_empty_o),
        .ext_en_i(ext_en_i), .ext_wr_i(ext_wr_i), .ext_adr_i(ext_adr_i),
        .ext_dat_i(ext_dat_i), .ext_ack_o(ext_ack_o), .ext_dat_o(ext_dat_o),
        .ctrl_o(ctrl_o)
    );

    task automatic check_word(input string name, input logic [turf_pkg::DAT_W-1:0] exp,
                              input logic [turf_pkg::DAT_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %s: expected %08h, actual %08h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s: expected %b, actual %b", name, exp, act);
            err_count++;
        end
    endtask

    task automatic push_word(input logic [turf_pkg::DAT_W-1:0] word);
        int waited;
        waited = 0;
        @(negedge clk);
        while (req_full_o && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (req_full_o) begin
            $display("timeout: request queue stayed full, word %08h was not written", word);
            timeout_count++;
        end else begin
            req_data_i = word;
            req_wren_i = 1'b1;
            @(negedge clk);
            req_wren_i = 1'b0;
        end
    endtask

    task automatic host_write_pair(input logic [3:0] op, input logic [turf_pkg::ADR_W-1:0] adr,
                                   input logic [turf_pkg::DAT_W-1:0] dat);
        push_word({op, adr});
        push_word(dat);
    endtask

    task automatic host_read_word(input string name, output logic [turf_pkg::DAT_W-1:0] data);
        int waited;
        waited = 0;
        data = '0;
        @(negedge clk);
        while (resp_empty_o && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (resp_empty_o) begin
            $display("timeout in %s: no response word arrived", name);
            timeout_count++;
        end else begin
            data = resp_data_o;
            resp_rden_i = 1'b1;
            @(negedge clk);
            resp_rden_i = 1'b0;
        end
    endtask

    task automatic host_read_reg(input string name, input logic [turf_pkg::ADR_W-1:0] adr,
                                 output logic [turf_pkg::DAT_W-1:0] data);
        // data word of a read pair is ignored, so send noise
        host_write_pair(turf_pkg::MM_OP_READ, adr, $urandom());
        host_read_word(name, data);
    endtask

    task automatic ext_access(input string name, input logic wr,
                              input logic [turf_pkg::ADR_W-1:0] adr,
                              input logic [turf_pkg::DAT_W-1:0] dat,
                              output logic [turf_pkg::DAT_W-1:0] rdat);
        int waited;
        waited = 0;
        rdat = '0;
        @(negedge clk);
        ext_en_i = 1'b1;
        ext_wr_i = wr;
        ext_adr_i = adr;
        ext_dat_i = dat;
        @(negedge clk);
        while (!ext_ack_o && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!ext_ack_o) begin
            $display("timeout in %s: external access was never acknowledged", name);
            timeout_count++;
        end else begin
            rdat = ext_dat_o;
        end
        // dropped inside the ack cycle so no second grant follows
        ext_en_i = 1'b0;
    endtask

    task automatic wait_ctrl(input string name, input logic [turf_pkg::DAT_W-1:0] exp);
        int waited;
        waited = 0;
        while (ctrl_o !== exp && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        check_word(name, exp, ctrl_o);
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_flag("reset req_full_o", 1'b0, req_full_o);
        check_flag("reset resp_empty_o", 1'b1, resp_empty_o);
        check_flag("reset ext_ack_o", 1'b0, ext_ack_o);
        check_word("reset ctrl_o", '0, ctrl_o);
    endtask

    task automatic test_ident();
        logic [turf_pkg::DAT_W-1:0] rdat;
        host_read_reg("ident", turf_pkg::REG_IDENT, rdat);
        check_word("ident", EXP_IDENT, rdat);
        host_read_reg("dateversion", turf_pkg::REG_DATEVERSION, rdat);
        check_word("dateversion", EXP_DATEVERSION, rdat);
    endtask

    task automatic test_ctrl_write();
        logic [turf_pkg::DAT_W-1:0] value;
        logic [turf_pkg::DAT_W-1:0] rdat;
        value = $urandom();
        host_write_pair(turf_pkg::MM_OP_WRITE, turf_pkg::REG_CTRL, value);
        ctrl_model = value;
        wait_ctrl("ctrl write ctrl_o", value);
        host_read_reg("ctrl readback", turf_pkg::REG_CTRL, rdat);
        check_word("ctrl readback", value, rdat);
    endtask

    task automatic test_ext_scratch();
        logic [turf_pkg::DAT_W-1:0] value;
        logic [turf_pkg::DAT_W-1:0] rdat;
        value = $urandom();
        ext_access("ext scratch write", 1'b1, turf_pkg::REG_SCRATCH, value, rdat);
        ext_access("ext scratch read", 1'b0, turf_pkg::REG_SCRATCH, '0, rdat);
        check_word("ext scratch read", value, rdat);
        ext_access("ext unmapped read", 1'b0, 28'd9, '0, rdat);
        check_word("ext unmapped read", '0, rdat);
    endtask

    task automatic test_concurrent();
        logic [turf_pkg::DAT_W-1:0] host_val;
        logic [turf_pkg::DAT_W-1:0] ext_val;
        logic [turf_pkg::DAT_W-1:0] ext_rdat;
        logic [turf_pkg::DAT_W-1:0] rdat;
        host_val = $urandom();
        ext_val = $urandom();
        // ext request is delayed so it lands near the decoder's bus access
        fork
            host_write_pair(turf_pkg::MM_OP_WRITE, turf_pkg::REG_CTRL, host_val);
            begin
                repeat (3) @(negedge clk);
                ext_access("concurrent ext write", 1'b1, turf_pkg::REG_SCRATCH, ext_val,
                           ext_rdat);
            end
        join
        ctrl_model = host_val;
        wait_ctrl("concurrent ctrl_o", host_val);
        host_read_reg("concurrent host scratch", turf_pkg::REG_SCRATCH, rdat);
        check_word("concurrent host scratch", ext_val, rdat);
        ext_access("concurrent ext ctrl", 1'b0, turf_pkg::REG_CTRL, '0, rdat);
        check_word("concurrent ext ctrl", host_val, rdat);
    endtask

    task automatic test_backpressure();
        logic [turf_pkg::DAT_W-1:0] value;
        logic [turf_pkg::DAT_W-1:0] rdat;
        int waited;
        int i;
        value = $urandom();
        waited = 0;
        ext_access("backpressure setup", 1'b1, turf_pkg::REG_SCRATCH, value, rdat);
        for (i = 0; i < FILL_PAIRS; i++) begin
            host_write_pair(turf_pkg::MM_OP_READ, turf_pkg::REG_SCRATCH, '0);
        end
        while (!req_full_o && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        check_flag("backpressure req_full_o", 1'b1, req_full_o);
        for (i = 0; i < FILL_PAIRS; i++) begin
            host_read_word("backpressure drain", rdat);
            check_word("backpressure drain", value, rdat);
        end
        check_flag("backpressure drained resp_empty_o", 1'b1, resp_empty_o);
        check_flag("backpressure drained req_full_o", 1'b0, req_full_o);
    endtask

    task automatic test_unknown_op();
        logic [turf_pkg::DAT_W-1:0] rdat;
        int waited;
        waited = 0;
        host_write_pair(4'hF, turf_pkg::REG_CTRL, ~ctrl_model);
        // watch while the decoder consumes the pair, no response may show up
        while (resp_empty_o && waited < QUIET_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        check_flag("unknown op resp_empty_o", 1'b1, resp_empty_o);
        // the next response must belong to this read, not to the unknown pair
        host_read_reg("unknown op ctrl readback", turf_pkg::REG_CTRL, rdat);
        check_word("unknown op ctrl readback", ctrl_model, rdat);
        check_flag("unknown op single response", 1'b1, resp_empty_o);
        check_word("unknown op ctrl_o", ctrl_model, ctrl_o);
    endtask

    initial begin
        err_count = 0;
        timeout_count = 0;
        ctrl_model = '0;
        void'($urandom(32'h9667));
        reset_i = 1'b1;
        req_data_i = '0;
        req_wren_i = 1'b0;
        resp_rden_i = 1'b0;
        ext_en_i = 1'b0;
        ext_wr_i = 1'b0;
        ext_adr_i = '0;
        ext_dat_i = '0;
        repeat (8) @(negedge clk);
        reset_i = 1'b0;

        test_reset_state();
        test_ident();
        test_ctrl_write();
        test_ext_scratch();
        test_concurrent();
        test_backpressure();
        test_unknown_op();

        repeat (2) @(negedge clk);
        total_fails = err_count + timeout_count + int'(uut.u_checker.assert_fails);
        $display("mismatches %0d, timeouts %0d, assertion failures %0d",
                 err_count, timeout_count, uut.u_checker.assert_fails);
        if (total_fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
design/turf_pkg.sv
design/mm_fifo.sv
design/mm_req_decoder.sv
design/bus_arbiter.sv
design/turf_register_core.sv
design/turf_host_bridge.sv
test/tb_clock_gen.sv
test/turf_host_bridge_checker.sv
test/tb_turf_host_bridge.sv
